/* hdl/fftPkg.sv */
`default_nettype none

package fftPkg;

	// Transform size
	localparam int FftPoints = 8;
	localparam int FftLog2 = 3;
	localparam int Butterflies = FftPoints / 2;

	// Fixed-point formats
	localparam int SampleWidth = 12;
	localparam int DataWidth = 24;
	localparam int FracBits = 8;

	// Wide enough to hold +1.0 as 256
	localparam int CoefWidth = 10;

	// Raw input sample
	typedef logic signed [SampleWidth-1:0] sample_t;

	// Working value inside the pipeline, FracBits below the point
	typedef logic signed [DataWidth-1:0] data_t;

	// Twiddle factor
	typedef logic signed [CoefWidth-1:0] coef_t;

	// Position within a frame
	typedef logic [FftLog2-1:0] index_t;

	// Butterfly stage sequencing
	typedef enum logic [1:0] {
		stIdle,
		stCompute,
		stHold
	} stageState_t;

	// W^k = cos(2*pi*k/8) - i*sin(2*pi*k/8), scaled by 256 and rounded
	localparam coef_t TwiddleReal [Butterflies] = '{
		10'sd256,
		10'sd181,
		10'sd0,
		-10'sd181
	};

	localparam coef_t TwiddleImag [Butterflies] = '{
		10'sd0,
		-10'sd181,
		-10'sd256,
		-10'sd181
	};

endpackage

`default_nettype wire

/* hdl/frameIf.sv */
`timescale 1ns/1ps
`default_nettype none

// One complex frame per transfer, valid/ready handshake
interface frameIf;

	logic valid;
	logic ready;
	fftPkg::data_t re [fftPkg::FftPoints];
	fftPkg::data_t im [fftPkg::FftPoints];

	// Producer side
	modport source (
		output valid,
		output re,
		output im,
		input ready
	);

	// Consumer side
	modport sink (
		input valid,
		input re,
		input im,
		output ready
	);

endinterface

`default_nettype wire

/* hdl/sampleWindow.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleWindow (
	input logic clk,
	input logic reset,
	input fftPkg::sample_t sample,
	input logic advance,
	frameIf.source frameOut
);

	// Index 0 holds the newest sample
	fftPkg::sample_t window [fftPkg::FftPoints];
	fftPkg::sample_t nextWindow [fftPkg::FftPoints];
	fftPkg::data_t shuffled [fftPkg::FftPoints];
	logic frameValid;
	logic loadFrame;

	function automatic fftPkg::index_t bitReverse(input fftPkg::index_t idx);
		fftPkg::index_t rev;
		for (int i = 0; i < fftPkg::FftLog2; i++) begin
			rev[i] = idx[fftPkg::FftLog2-1-i];
		end
		return rev;
	endfunction

	// Window as it will look after this advance
	always_comb begin
		nextWindow[0] = sample;
		for (int i = 1; i < fftPkg::FftPoints; i++) begin
			nextWindow[i] = window[i-1];
		end
	end

	// Bit-reversed order, sign-extended and lifted to the fixed-point scale
	always_comb begin
		for (int j = 0; j < fftPkg::FftPoints; j++) begin
			shuffled[j] = fftPkg::data_t'(nextWindow[bitReverse(fftPkg::index_t'(j))])
				<<< fftPkg::FracBits;
		end
	end

	// A new frame only fits when the register is free or draining now
	assign loadFrame = advance && (!frameValid || frameOut.ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < fftPkg::FftPoints; i++) begin
				window[i] <= '0;
			end
		end else if (advance) begin
			window <= nextWindow;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frameValid <= 1'b0;
		end else if (loadFrame) begin
			frameValid <= 1'b1;
		end else if (frameOut.ready) begin
			frameValid <= 1'b0;
		end
	end

	// Frame register
	always_ff @(posedge clk) begin
		if (loadFrame) begin
			for (int j = 0; j < fftPkg::FftPoints; j++) begin
				frameOut.re[j] <= shuffled[j];
				frameOut.im[j] <= '0;
			end
		end
	end

	assign frameOut.valid = frameValid;

	// Offered frame is not withdrawn before the first stage takes it
	holdUntilTaken: assert property (@(posedge clk) disable iff (reset)
		frameOut.valid && !frameOut.ready |=> frameOut.valid);

endmodule

`default_nettype wire

/* hdl/butterflyStage.sv */
`timescale 1ns/1ps
`default_nettype none

module butterflyStage #(
	parameter int StageIndex = 0
) (
	input logic clk,
	input logic reset,
	frameIf.sink frameIn,
	frameIf.source frameOut
);

	fftPkg::stageState_t state;
	logic [fftPkg::FftLog2-2:0] counter;
	logic [fftPkg::FftLog2-2:0] twiddleIndex;
	logic takeIn;
	logic lastButterfly;

	// Frame being worked on in place
	fftPkg::data_t workRe [fftPkg::FftPoints];
	fftPkg::data_t workIm [fftPkg::FftPoints];

	fftPkg::index_t aIndex;
	fftPkg::index_t bIndex;
	fftPkg::data_t wRe;
	fftPkg::data_t wIm;
	fftPkg::data_t bRe;
	fftPkg::data_t bIm;
	fftPkg::data_t prodRe;
	fftPkg::data_t prodIm;

	// Butterfly pair and twiddle from the counter, half span 2^StageIndex
	always_comb begin
		int lowPart;
		int group;
		lowPart = int'(counter) & ((1 << StageIndex) - 1);
		group = int'(counter) >> StageIndex;
		aIndex = fftPkg::index_t'((group << (StageIndex + 1)) + lowPart);
		bIndex = fftPkg::index_t'((group << (StageIndex + 1)) + lowPart + (1 << StageIndex));
		twiddleIndex = (fftPkg::FftLog2-1)'(lowPart << (fftPkg::FftLog2 - 1 - StageIndex));
	end

	// W times b, with b scaled down first so the product stays in range
	always_comb begin
		wRe = fftPkg::data_t'(fftPkg::TwiddleReal[twiddleIndex]);
		wIm = fftPkg::data_t'(fftPkg::TwiddleImag[twiddleIndex]);
		bRe = workRe[bIndex] >>> fftPkg::FracBits;
		bIm = workIm[bIndex] >>> fftPkg::FracBits;
		prodRe = wRe * bRe - wIm * bIm;
		prodIm = wRe * bIm + wIm * bRe;
	end

	assign frameIn.ready = (state == fftPkg::stIdle);
	assign frameOut.valid = (state == fftPkg::stHold);
	assign takeIn = frameIn.valid && frameIn.ready;
	assign lastButterfly = (counter == (fftPkg::FftLog2-1)'(fftPkg::Butterflies - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fftPkg::stIdle;
			counter <= '0;
		end else begin
			unique case (state)
				fftPkg::stIdle: begin
					if (takeIn) begin
						state <= fftPkg::stCompute;
					end
				end
				fftPkg::stCompute: begin
					// One butterfly per clock, counter wraps back to zero
					counter <= counter + 1'b1;
					if (lastButterfly) begin
						state <= fftPkg::stHold;
					end
				end
				fftPkg::stHold: begin
					if (frameOut.ready) begin
						state <= fftPkg::stIdle;
					end
				end
				default: begin
					state <= fftPkg::stIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (takeIn) begin
			workRe <= frameIn.re;
			workIm <= frameIn.im;
		end else if (state == fftPkg::stCompute) begin
			workRe[aIndex] <= workRe[aIndex] + prodRe;
			workIm[aIndex] <= workIm[aIndex] + prodIm;
			workRe[bIndex] <= workRe[aIndex] - prodRe;
			workIm[bIndex] <= workIm[aIndex] - prodIm;
		end
	end

	// Held frame is the work register itself
	always_comb begin
		frameOut.re = workRe;
		frameOut.im = workIm;
	end

	idleCounterClear: assert property (@(posedge clk) disable iff (reset)
		state == fftPkg::stIdle |-> counter == '0);

endmodule

`default_nettype wire

/* hdl/spectrumStore.sv */
`timescale 1ns/1ps
`default_nettype none

module spectrumStore (
	input logic clk,
	input logic reset,
	frameIf.sink frameIn,
	input logic readHold,
	input fftPkg::index_t readAddress,
	output fftPkg::data_t readData,
	output logic outValid
);

	// Real parts of the last finished frame
	fftPkg::data_t spectrum [fftPkg::FftPoints];
	logic takeFrame;

	// Reader holding the data blocks the pipeline
	assign frameIn.ready = !readHold;
	assign takeFrame = frameIn.valid && frameIn.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			for (int i = 0; i < fftPkg::FftPoints; i++) begin
				spectrum[i] <= '0;
			end
		end else begin
			outValid <= takeFrame;
			if (takeFrame) begin
				spectrum <= frameIn.re;
			end
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		readData <= spectrum[readAddress];
	end

	// Held results stay put across the hold
	for (genvar i = 0; i < fftPkg::FftPoints; i++) begin : gHoldCheck
		holdStable: assert property (@(posedge clk) disable iff (reset)
			readHold |=> $stable(spectrum[i]));
	end

endmodule

`default_nettype wire

/* hdl/fftPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module fftPipeline (
	input logic clk,
	input logic reset,
	input fftPkg::sample_t sample,
	input logic advance,
	input logic readHold,
	input fftPkg::index_t readAddress,
	output fftPkg::data_t readData,
	output logic outValid
);

	// Window -> stage 0 -> stage 1 -> stage 2 -> store
	frameIf links [fftPkg::FftLog2+1] ();

	sampleWindow window_i (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.advance(advance),
		.frameOut(links[0])
	);

	// Stage s combines pairs 2^s apart
	for (genvar s = 0; s < fftPkg::FftLog2; s++) begin : gStage
		butterflyStage #(
			.StageIndex(s)
		) stage_i (
			.clk(clk),
			.reset(reset),
			.frameIn(links[s]),
			.frameOut(links[s+1])
		);
	end

	spectrumStore store_i (
		.clk(clk),
		.reset(reset),
		.frameIn(links[fftPkg::FftLog2]),
		.readHold(readHold),
		.readAddress(readAddress),
		.readData(readData),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

/* verification/fftModel.svh */
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// Eight real parts, element 0 is frequency bin 0
typedef logic [fftPkg::FftPoints-1:0][fftPkg::DataWidth-1:0] spectrum_t;

// Sample history, element 0 is the newest sample
typedef logic [fftPkg::FftPoints-1:0][fftPkg::SampleWidth-1:0] window_t;

localparam longint DataSpan = 64'sd1 <<< fftPkg::DataWidth;
localparam longint DataMask = DataSpan - 64'sd1;
localparam longint DataHalf = DataSpan >>> 1;

// W^k = cos(2*pi*k/8) - i*sin(2*pi*k/8), times 256
localparam longint CosTable [4] = '{64'sd256, 64'sd181, 64'sd0, -64'sd181};
localparam longint SinTable [4] = '{64'sd0, -64'sd181, -64'sd256, -64'sd181};

// 32-bit LCG step
function automatic logic [31:0] nextRandom(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// Two's complement wrap to the internal data width
function automatic longint wrapData(input longint value);
	longint low;
	low = value & DataMask;
	if (low >= DataHalf) begin
		low = low - DataSpan;
	end
	return low;
endfunction

function automatic int reverseBits(input int idx);
	int rev;
	rev = 0;
	for (int i = 0; i < fftPkg::FftLog2; i++) begin
		rev = (rev << 1) | ((idx >> i) & 1);
	end
	return rev;
endfunction

// Decimation in time over the bit-reversed frame, real parts out
function automatic spectrum_t referenceSpectrum(input window_t history);
	longint re [fftPkg::FftPoints];
	longint im [fftPkg::FftPoints];
	longint bRe;
	longint bIm;
	longint pRe;
	longint pIm;
	longint aRe;
	longint aIm;
	int half;
	int a;
	int b;
	int k;
	spectrum_t result;
	for (int j = 0; j < fftPkg::FftPoints; j++) begin
		re[j] = wrapData(longint'(signed'(history[fftPkg::index_t'(reverseBits(j))]))
			<<< fftPkg::FracBits);
		im[j] = 64'sd0;
	end
	for (int s = 0; s < fftPkg::FftLog2; s++) begin
		half = 1 << s;
		for (int c = 0; c < fftPkg::FftPoints / 2; c++) begin
			a = (c / half) * 2 * half + c % half;
			b = a + half;
			k = (c % half) * (fftPkg::FftPoints / (2 * half));
			// Scale b down before the twiddle product
			bRe = re[b] >>> fftPkg::FracBits;
			bIm = im[b] >>> fftPkg::FracBits;
			pRe = wrapData(CosTable[k] * bRe - SinTable[k] * bIm);
			pIm = wrapData(CosTable[k] * bIm + SinTable[k] * bRe);
			aRe = re[a];
			aIm = im[a];
			re[a] = wrapData(aRe + pRe);
			im[a] = wrapData(aIm + pIm);
			re[b] = wrapData(aRe - pRe);
			im[b] = wrapData(aIm - pIm);
		end
	end
	for (int j = 0; j < fftPkg::FftPoints; j++) begin
		result[fftPkg::index_t'(j)] = fftPkg::DataWidth'(re[j]);
	end
	return result;
endfunction

`endif

/* verification/fftPipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fftPipelineTb;

	localparam int ClockPeriod = 8;
	localparam int ImpulseAdvances = 8;
	localparam int RandomAdvances = 40;
	localparam int HoldAdvances = 3;
	localparam int WrapAdvances = 8;
	localparam int TotalAdvances = ImpulseAdvances + RandomAdvances + HoldAdvances + WrapAdvances;
	localparam int WatchdogCycles = TotalAdvances * 64 + 500;
	localparam fftPkg::sample_t FullNegative = {1'b1, {(fftPkg::SampleWidth-1){1'b0}}};
	localparam fftPkg::sample_t FullPositive = {1'b0, {(fftPkg::SampleWidth-1){1'b1}}};

	logic clk;
	logic reset;
	fftPkg::sample_t sample;
	logic advance;
	logic testHold;
	logic checkHold;
	logic readHold;
	fftPkg::index_t readAddress;
	fftPkg::data_t readData;
	logic outValid;

	`include "fftModel.svh"

	spectrum_t expectedQ [$];
	spectrum_t lastFrame;
	window_t history;
	logic [31:0] lcgState;
	int framesSent;
	int framesChecked;
	int recheckRequests;
	int recheckDone;

	// Either the hold test or the reader can stall the store
	assign readHold = testHold || checkHold;

	fftPipeline fftPipeline_i (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.advance(advance),
		.readHold(readHold),
		.readAddress(readAddress),
		.readData(readData),
		.outValid(outValid)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped on error");
	endtask

	// Starts on a falling edge, ends on the next one
	task automatic pushSample(input fftPkg::sample_t value);
		history = {history[fftPkg::FftPoints-2:0], value};
		sample = value;
		advance = 1'b1;
		expectedQ.push_back(referenceSpectrum(history));
		framesSent++;
		@(negedge clk);
		advance = 1'b0;
	endtask

	task automatic sendSpaced(input fftPkg::sample_t value, input int gap);
		pushSample(value);
		repeat (gap - 1) @(negedge clk);
	endtask

	task automatic sendRandom(input int gap);
		lcgState = nextRandom(lcgState);
		sendSpaced(fftPkg::sample_t'(lcgState[31 -: fftPkg::SampleWidth]), gap);
	endtask

	task automatic waitDrained();
		while (framesChecked != framesSent) begin
			@(negedge clk);
		end
	endtask

	task automatic waitRecheck();
		while (recheckDone != recheckRequests) begin
			@(negedge clk);
		end
	endtask

	// Read all bins, one address per cycle, store held throughout
	task automatic compareStore(input spectrum_t expected);
		fftPkg::data_t got;
		checkHold = 1'b1;
		readAddress = '0;
		for (int i = 0; i < fftPkg::FftPoints; i++) begin
			@(negedge clk);
			got = readData;
			assert (got == expected[fftPkg::index_t'(i)]) else
				failRun($sformatf("FAIL readData address %0h expected %h actual %h",
					i, expected[fftPkg::index_t'(i)], got));
			readAddress = fftPkg::index_t'(i + 1);
		end
		checkHold = 1'b0;
	endtask

	// Comparison process
	initial begin
		checkHold = 1'b0;
		readAddress = '0;
		framesChecked = 0;
		recheckDone = 0;
		lastFrame = '0;
		forever begin
			@(negedge clk);
			if (outValid) begin
				assert (expectedQ.size() != 0) else
					failRun("outValid pulsed with no frame outstanding");
				lastFrame = expectedQ.pop_front();
				compareStore(lastFrame);
				framesChecked++;
			end else if (recheckDone != recheckRequests) begin
				compareStore(lastFrame);
				recheckDone++;
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		failRun("watchdog expired before all tests finished");
	end

	initial begin
		int startCount;
		reset = 1'b1;
		advance = 1'b0;
		sample = '0;
		testHold = 1'b0;
		history = '0;
		lcgState = 32'h18c7_4f41;
		framesSent = 0;
		recheckRequests = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Quiet after reset, store cleared
		repeat (20) begin
			@(negedge clk);
			assert (!outValid) else failRun("outValid rose before any advance");
		end
		recheckRequests++;
		waitRecheck();

		// Impulse walking through the window
		sendSpaced(fftPkg::sample_t'(100), 40);
		repeat (ImpulseAdvances - 1) sendSpaced('0, 40);
		waitDrained();

		// Bursts of four keep several frames in flight without overflowing
		repeat (RandomAdvances / 4) begin
			repeat (4) sendRandom(6);
			waitDrained();
		end

		// Frames pile up behind a held store
		testHold = 1'b1;
		startCount = framesChecked;
		repeat (HoldAdvances) sendRandom(12);
		repeat (40) @(negedge clk);
		assert (framesChecked == startCount) else
			failRun("a frame reached the store while readHold was high");
		recheckRequests++;
		waitRecheck();
		testHold = 1'b0;
		waitDrained();

		// Full-scale extremes
		for (int i = 0; i < WrapAdvances; i++) begin
			sendSpaced((i < WrapAdvances / 2) ? FullNegative : FullPositive, 40);
		end
		waitDrained();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verification
hdl/fftPkg.sv
hdl/frameIf.sv
hdl/sampleWindow.sv
hdl/butterflyStage.sv
hdl/spectrumStore.sv
hdl/fftPipeline.sv
verification/fftPipelineTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := fftPipelineTb
FILELIST := verilog.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Verilator exits nonzero when the testbench calls $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
